/* project.f */
+incdir+include
src/mips_pkg.sv
src/control.sv
src/instr_fetch.sv
src/reg_file.sv
src/decode_latch.sv
src/execute_unit.sv
src/mips_core.sv
bench/mips_core_assert.sv
bench/mips_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the mips_core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -f project.f --top-module mips_core_tb -o mips_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/mips_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* bench/mips_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module mips_core_tb;

    import mips_pkg::*;

    localparam int         NUM_PROGS       = 20;
    localparam int         WATCHDOG_CYCLES = NUM_PROGS * (`MIPS_IMEM_DEPTH + 10) + 50;
    localparam logic [5:0] OPC_LW          = 6'b100011;
    localparam logic [5:0] FN_JR           = 6'b001000;

    logic                     clk;
    logic                     rst;
    logic                     imem_we;
    logic [`MIPS_IMEM_AW-1:0] imem_addr;
    logic [31:0]              imem_data;
    logic                     start;
    logic [6:0]               prog_len;
    logic                     busy;
    logic                     wb_valid;
    logic [4:0]               wb_addr;
    logic [31:0]              wb_data;

    logic [31:0] mregs [0:`MIPS_REG_COUNT-1];
    logic [31:0] prog [0:`MIPS_IMEM_DEPTH-1];
    int          prog_n;
    logic [4:0]  exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] lfsr;
    int          mismatch_count;
    int          other_count;

    mips_core mips_core_i (
        .clk       (clk),
        .rst       (rst),
        .imem_we   (imem_we),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .start     (start),
        .prog_len  (prog_len),
        .busy      (busy),
        .wb_valid  (wb_valid),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data)
    );

    always begin
        clk = 1'b0;
        #5;
        clk = 1'b1;
        #5;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // mostly r0..r7, so neighbours depend on each other.
    task automatic pick_reg(output logic [4:0] r);
        logic [31:0] v;
        take_bits(3, v);
        if (v[2:0] == 3'd0) begin
            take_bits(5, v);
        end else begin
            take_bits(3, v);
        end
        r = v[4:0];
    endtask

    function automatic logic [31:0] r_op(input logic [5:0] fn, input logic [4:0] rd,
                                         input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] shamt);
        return {OPC_RTYPE, rs, rt, rd, shamt, fn};
    endfunction

    function automatic logic [31:0] i_op(input logic [5:0] opc, input logic [4:0] rt,
                                         input logic [4:0] rs, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic logic [5:0] rfunct(input logic [3:0] idx);
        case (idx)
            4'd0:    return FN_SLL;
            4'd1:    return FN_SRL;
            4'd2:    return FN_SRA;
            4'd3:    return FN_ADD;
            4'd4:    return FN_ADDU;
            4'd5:    return FN_SUB;
            4'd6:    return FN_AND;
            4'd7:    return FN_OR;
            4'd8:    return FN_XOR;
            default: return FN_SLT;
        endcase
    endfunction

    // r1 = 0x80010f0f and r2 = -5 beforehand.
    function automatic logic [31:0] single_op(input int idx);
        case (idx)
            10:      return i_op(OPC_ADDI, 5'd3, 5'd1, 16'hfff0);
            11:      return i_op(OPC_ADDIU, 5'd3, 5'd2, 16'h8000);
            12:      return i_op(OPC_XORI, 5'd3, 5'd1, 16'h8421);
            13:      return i_op(OPC_ORI, 5'd3, 5'd2, 16'h8421);
            14:      return i_op(OPC_LUI, 5'd3, 5'd0, 16'hbeef);
            default: return r_op(rfunct(idx[3:0]), 5'd3, 5'd1, 5'd2, 5'd4);
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic model_step(input logic [31:0] w);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] res;
        logic        ok;
        rs   = w[25:21];
        rt   = w[20:16];
        a    = mregs[rs];
        b    = mregs[rt];
        simm = {{16{w[15]}}, w[15:0]};
        dst  = rt;
        res  = '0;
        ok   = 1'b1;
        case (w[31:26])
            OPC_RTYPE: begin
                dst = w[15:11];
                case (w[5:0])
                    FN_SLL:          res = b << w[10:6];
                    FN_SRL:          res = b >> w[10:6];
                    FN_SRA:          res = $signed(b) >>> w[10:6];
                    FN_ADD, FN_ADDU: res = a + b;
                    FN_SUB:          res = a - b;
                    FN_AND:          res = a & b;
                    FN_OR:           res = a | b;
                    FN_XOR:          res = a ^ b;
                    FN_SLT:          res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:         ok  = 1'b0;
                endcase
            end
            OPC_ADDI, OPC_ADDIU: res = a + simm;
            OPC_XORI:            res = a ^ simm;
            OPC_ORI:             res = a | {16'd0, w[15:0]};
            OPC_LUI:             res = {w[15:0], 16'd0};
            default:             ok  = 1'b0;
        endcase
        if (ok && dst != 5'd0) begin
            mregs[dst] = res;
            exp_addr.push_back(dst);
            exp_data.push_back(res);
        end
    endtask

    task automatic emit(input logic [31:0] w);
        prog[prog_n] = w;
        model_step(w);
        prog_n++;
    endtask

    task automatic emit_random();
        logic [31:0] sel;
        logic [31:0] sh;
        logic [31:0] imm;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        take_bits(4, sel);
        take_bits(5, sh);
        take_bits(16, imm);
        pick_reg(rs);
        pick_reg(rt);
        pick_reg(rd);
        case (sel[3:0])
            4'd10:   emit(i_op(OPC_ADDI, rt, rs, imm[15:0]));
            4'd11:   emit(i_op(OPC_ADDIU, rt, rs, imm[15:0]));
            4'd12:   emit(i_op(OPC_XORI, rt, rs, imm[15:0]));
            4'd13:   emit(i_op(OPC_ORI, rt, rs, imm[15:0]));
            4'd14:   emit(i_op(OPC_LUI, rt, rs, imm[15:0]));
            4'd15:   emit(i_op(OPC_LW, rt, rs, imm[15:0]));
            default: emit(r_op(rfunct(sel[3:0]), rd, rs, rt, sh[4:0]));
        endcase
    endtask

    // load, start, wait for busy to drop, then let the pipe drain.
    task automatic run_program(input logic extra_start);
        for (int i = 0; i < prog_n; i++) begin
            @(posedge clk);
            imem_we   <= 1'b1;
            imem_addr <= i[`MIPS_IMEM_AW-1:0];
            imem_data <= prog[i];
        end
        @(posedge clk);
        imem_we  <= 1'b0;
        start    <= 1'b1;
        prog_len <= prog_n[6:0];
        @(posedge clk);
        start <= 1'b0;
        if (extra_start) begin
            repeat (2) @(posedge clk);
            start    <= 1'b1;
            prog_len <= 7'd5;
            @(posedge clk);
            start <= 1'b0;
        end
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        assert (exp_addr.size() == 0) else begin
            $display("missing write-back: %0d expected writes never came, at %0t",
                     exp_addr.size(), $time);
            other_count++;
            exp_addr.delete();
            exp_data.delete();
        end
        prog_n = 0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // write-back monitor
    // ~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (!rst && wb_valid) begin
            if (exp_addr.size() == 0) begin
                $display("unexpected write-back to r%0d at %0t", wb_addr, $time);
                other_count++;
            end else begin
                assert (wb_addr == exp_addr[0]) else begin
                    $display("Mismatch at %0t: wb_addr got %0d expected %0d",
                             $time, wb_addr, exp_addr[0]);
                    mismatch_count++;
                end
                assert (wb_data == exp_data[0]) else begin
                    $display("Mismatch at %0t: wb_data got %h expected %h",
                             $time, wb_data, exp_data[0]);
                    mismatch_count++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("timeout after %0d cycles", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

    initial begin
        rst            <= 1'b1;
        imem_we        <= 1'b0;
        imem_addr      <= '0;
        imem_data      <= '0;
        start          <= 1'b0;
        prog_len       <= '0;
        lfsr           = 32'h5806e162;
        prog_n         = 0;
        mismatch_count = 0;
        other_count    = 0;
        for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
            mregs[i] = '0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // idle after reset.
        repeat (8) begin
            @(negedge clk);
            assert (!busy) else begin
                $display("Mismatch at %0t: busy got %b expected 0", $time, busy);
                mismatch_count++;
            end
            assert (!wb_valid) else begin
                $display("Mismatch at %0t: wb_valid got %b expected 0", $time, wb_valid);
                mismatch_count++;
            end
        end

        // or rd, rs, $0 over cleared registers.
        for (int i = 0; i < 8; i++) begin
            emit(r_op(FN_OR, 5'(i % 7 + 1), 5'(7 - i), 5'd0, 5'd0));
        end
        run_program(1'b0);

        for (int k = 0; k < 15; k++) begin
            emit(i_op(OPC_LUI, 5'd1, 5'd0, 16'h8001));
            emit(i_op(OPC_ORI, 5'd1, 5'd1, 16'h0f0f));
            emit(i_op(OPC_ADDI, 5'd2, 5'd0, 16'hfffb));
            emit(single_op(k));
            run_program(1'b0);
        end

        // back-to-back chain through the bypass.
        emit(i_op(OPC_ADDI, 5'd1, 5'd0, 16'd7));
        emit(r_op(FN_SLL, 5'd2, 5'd0, 5'd1, 5'd3));
        emit(r_op(FN_ADD, 5'd3, 5'd2, 5'd1, 5'd0));
        emit(r_op(FN_SUB, 5'd4, 5'd1, 5'd3, 5'd0));
        emit(r_op(FN_SLT, 5'd5, 5'd4, 5'd3, 5'd0));
        emit(r_op(FN_XOR, 5'd6, 5'd5, 5'd4, 5'd0));
        emit(i_op(OPC_ORI, 5'd7, 5'd6, 16'h00f0));
        emit(r_op(FN_AND, 5'd1, 5'd7, 5'd3, 5'd0));
        run_program(1'b0);

        // nothing here writes except the last one.
        emit(i_op(OPC_LW, 5'd3, 5'd1, 16'h0004));
        emit(r_op(FN_JR, 5'd3, 5'd1, 5'd2, 5'd0));
        emit(i_op(OPC_ADDI, 5'd0, 5'd1, 16'h0011));
        emit(r_op(FN_OR, 5'd0, 5'd1, 5'd2, 5'd0));
        emit(i_op(OPC_LUI, 5'd0, 5'd0, 16'h1234));
        emit(i_op(OPC_ADDIU, 5'd3, 5'd0, 16'd1));
        run_program(1'b0);

        for (int i = 0; i < `MIPS_IMEM_DEPTH; i++) begin
            emit_random();
        end
        run_program(1'b0);

        // second start lands while busy.
        for (int i = 0; i < 16; i++) begin
            emit_random();
        end
        run_program(1'b1);

        $display("errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatch_count, other_count, mips_core_i.mips_core_assert_i.fail_count);
        if (mismatch_count == 0 && other_count == 0 &&
            mips_core_i.mips_core_assert_i.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/mips_core_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_core_assert (
    input logic       clk,
    input logic       rst,
    input logic       start,
    input logic [6:0] prog_len,
    input logic       busy,
    input logic       wb_valid,
    input logic [4:0] wb_addr
);

    logic [6:0] run_len;
    logic [6:0] run_cnt;
    int         fail_count;

    initial begin
        fail_count = 0;
    end

    // length of the accepted run and cycles issued so far.
    always_ff @(posedge clk) begin
        if (rst) begin
            run_len <= '0;
            run_cnt <= '0;
        end else if (start && !busy) begin
            run_len <= prog_len;
            run_cnt <= '0;
        end else if (busy) begin
            run_cnt <= run_cnt + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // properties
    // ~~~~~~~~~~~~~~~~~~~~
    wb_addr_nonzero: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> wb_addr != 5'd0)
        else begin
            $error("write-back addressed register 0");
            fail_count++;
        end

    // execute trails issue by one cycle.
    wb_after_issue: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> $past(busy))
        else begin
            $error("write-back without an issued instruction");
            fail_count++;
        end

    busy_length: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> run_cnt == run_len)
        else begin
            $error("busy length differs from prog_len");
            fail_count++;
        end

endmodule

bind mips_core mips_core_assert mips_core_assert_i (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .prog_len (prog_len),
    .busy     (busy),
    .wb_valid (wb_valid),
    .wb_addr  (wb_addr)
);

`default_nettype wire

/* src/mips_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module mips_core (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     imem_we,
    input  logic [`MIPS_IMEM_AW-1:0] imem_addr,
    input  logic [31:0]              imem_data,
    input  logic                     start,
    input  logic [6:0]               prog_len,
    output logic                     busy,
    output logic                     wb_valid,
    output logic [4:0]               wb_addr,
    output logic [31:0]              wb_data
);

    import mips_pkg::*;

    instr_word_t instr;
    logic        instr_valid;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [31:0] rd_a;
    logic [31:0] rd_b;
    logic        ex_valid;
    logic [2:0]  ex_alu_op;
    logic [1:0]  ex_alu_src;
    logic        ex_reg_dst;
    logic        ex_reg_write;
    logic [31:0] ex_a;
    logic [31:0] ex_b;
    logic [31:0] ex_imm;
    logic [4:0]  ex_shamt;
    logic [5:0]  ex_funct;
    logic [4:0]  ex_rt;
    logic [4:0]  ex_rd;

    // ~~~~~~~~~~~~~~~~~~~~
    // fetch
    // ~~~~~~~~~~~~~~~~~~~~
    instr_fetch instr_fetch_i (
        .clk         (clk),
        .rst         (rst),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .start       (start),
        .prog_len    (prog_len),
        .instr       (instr),
        .instr_valid (instr_valid),
        .busy        (busy)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // decode
    // ~~~~~~~~~~~~~~~~~~~~
    decode_latch decode_latch_i (
        .clk          (clk),
        .rst          (rst),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .rd_a         (rd_a),
        .rd_b         (rd_b),
        .ra           (ra),
        .rb           (rb),
        .ex_valid     (ex_valid),
        .ex_alu_op    (ex_alu_op),
        .ex_alu_src   (ex_alu_src),
        .ex_reg_dst   (ex_reg_dst),
        .ex_reg_write (ex_reg_write),
        .ex_a         (ex_a),
        .ex_b         (ex_b),
        .ex_imm       (ex_imm),
        .ex_shamt     (ex_shamt),
        .ex_funct     (ex_funct),
        .ex_rt        (ex_rt),
        .ex_rd        (ex_rd)
    );

    // written by execute in the same cycle it is read.
    reg_file reg_file_i (
        .clk  (clk),
        .rst  (rst),
        .ra   (ra),
        .rb   (rb),
        .wa   (wb_addr),
        .wd   (wb_data),
        .we   (wb_valid),
        .rd_a (rd_a),
        .rd_b (rd_b)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // execute
    // ~~~~~~~~~~~~~~~~~~~~
    execute_unit execute_unit_i (
        .ex_valid     (ex_valid),
        .ex_alu_op    (ex_alu_op),
        .ex_alu_src   (ex_alu_src),
        .ex_reg_dst   (ex_reg_dst),
        .ex_reg_write (ex_reg_write),
        .ex_a         (ex_a),
        .ex_b         (ex_b),
        .ex_imm       (ex_imm),
        .ex_shamt     (ex_shamt),
        .ex_funct     (ex_funct),
        .ex_rt        (ex_rt),
        .ex_rd        (ex_rd),
        .wb_valid     (wb_valid),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data)
    );

endmodule

`default_nettype wire

/* src/execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  logic        ex_valid,
    input  logic [2:0]  ex_alu_op,
    input  logic [1:0]  ex_alu_src,
    input  logic        ex_reg_dst,
    input  logic        ex_reg_write,
    input  logic [31:0] ex_a,
    input  logic [31:0] ex_b,
    input  logic [31:0] ex_imm,
    input  logic [4:0]  ex_shamt,
    input  logic [5:0]  ex_funct,
    input  logic [4:0]  ex_rt,
    input  logic [4:0]  ex_rd,
    output logic        wb_valid,
    output logic [4:0]  wb_addr,
    output logic [31:0] wb_data
);

    import mips_pkg::*;

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] result;
    logic        op_ok;

    // shifts take shamt as a and rt as b.
    assign op_a = ex_alu_src[0] ? {27'd0, ex_shamt} : ex_a;
    assign op_b = ex_alu_src[1] ? ex_imm : ex_b;

    // ~~~~~~~~~~~~~~~~~~~~
    // alu
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        result = 32'd0;
        op_ok  = 1'b1;
        case (ex_alu_op)
            ALU_RTYPE: begin
                case (ex_funct)
                    FN_SLL:          result = op_b << op_a[4:0];
                    FN_SRL:          result = op_b >> op_a[4:0];
                    FN_SRA:          result = $unsigned($signed(op_b) >>> op_a[4:0]);
                    FN_ADD, FN_ADDU: result = op_a + op_b;
                    FN_SUB:          result = op_a - op_b;
                    FN_AND:          result = op_a & op_b;
                    FN_OR:           result = op_a | op_b;
                    FN_XOR:          result = op_a ^ op_b;
                    FN_SLT:          result = {31'd0, $signed(op_a) < $signed(op_b)};
                    default:         op_ok  = 1'b0;
                endcase
            end
            ALU_ADDI, ALU_ADDIU: result = op_a + op_b;
            ALU_XORI:            result = op_a ^ op_b;
            ALU_ORI:             result = op_a | op_b;
            ALU_LUI:             result = {op_b[15:0], 16'd0};
            default:             op_ok  = 1'b0;
        endcase
    end

    assign wb_addr  = ex_reg_dst ? ex_rd : ex_rt;
    assign wb_data  = result;

    // no write-back to register 0 or for an unknown op.
    assign wb_valid = ex_valid && ex_reg_write && op_ok && (wb_addr != 5'd0);

endmodule

`default_nettype wire

/* src/decode_latch.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_latch (
    input  logic                  clk,
    input  logic                  rst,
    input  mips_pkg::instr_word_t instr,
    input  logic                  instr_valid,
    input  logic [31:0]           rd_a,
    input  logic [31:0]           rd_b,
    output logic [4:0]            ra,
    output logic [4:0]            rb,
    output logic                  ex_valid,
    output logic [2:0]            ex_alu_op,
    output logic [1:0]            ex_alu_src,
    output logic                  ex_reg_dst,
    output logic                  ex_reg_write,
    output logic [31:0]           ex_a,
    output logic [31:0]           ex_b,
    output logic [31:0]           ex_imm,
    output logic [4:0]            ex_shamt,
    output logic [5:0]            ex_funct,
    output logic [4:0]            ex_rt,
    output logic [4:0]            ex_rd
);

    logic        reg_dst;
    logic [1:0]  alu_src;
    logic        reg_write;
    logic [2:0]  alu_op;
    logic        do_extend;
    logic [31:0] imm_ext;

    // memory and flow outputs stay open.
    control control_i (
        .opcode     (instr.r.opcode),
        .func       (instr.r.funct),
        .reg_dst    (reg_dst),
        .alu_src    (alu_src),
        .mem_to_reg (),
        .reg_write  (reg_write),
        .mem_read   (),
        .mem_write  (),
        .branch     (),
        .alu_op     (alu_op),
        .jump       (),
        .do_extend  (do_extend)
    );

    assign ra = instr.i.rs;
    assign rb = instr.i.rt;

    assign imm_ext = do_extend ? {{16{instr.i.imm[15]}}, instr.i.imm}
                               : {16'd0, instr.i.imm};

    // ~~~~~~~~~~~~~~~~~~~~
    // pipeline register
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid     <= 1'b0;
            ex_alu_op    <= '0;
            ex_alu_src   <= '0;
            ex_reg_dst   <= 1'b0;
            ex_reg_write <= 1'b0;
        end else begin
            ex_valid     <= instr_valid;
            ex_alu_op    <= alu_op;
            ex_alu_src   <= alu_src;
            ex_reg_dst   <= reg_dst;
            ex_reg_write <= reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            ex_a     <= rd_a;
            ex_b     <= rd_b;
            ex_imm   <= imm_ext;
            ex_shamt <= instr.r.shamt;
            ex_funct <= instr.r.funct;
            ex_rt    <= instr.r.rt;
            ex_rd    <= instr.r.rd;
        end
    end

endmodule

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module reg_file (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [$clog2(`MIPS_REG_COUNT)-1:0] ra,
    input  logic [$clog2(`MIPS_REG_COUNT)-1:0] rb,
    input  logic [$clog2(`MIPS_REG_COUNT)-1:0] wa,
    input  logic [31:0]                        wd,
    input  logic                               we,
    output logic [31:0]                        rd_a,
    output logic [31:0]                        rd_b
);

    logic [31:0] regs [0:`MIPS_REG_COUNT-1];
    logic        wr_ok;

    // register 0 never takes a write.
    assign wr_ok = we && (wa != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wa] <= wd;
        end
    end

    // write-first bypass on both ports.
    assign rd_a = (ra == '0) ? 32'd0 : (wr_ok && wa == ra) ? wd : regs[ra];
    assign rd_b = (rb == '0) ? 32'd0 : (wr_ok && wa == rb) ? wd : regs[rb];

endmodule

`default_nettype wire

/* src/instr_fetch.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module instr_fetch (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     imem_we,
    input  logic [`MIPS_IMEM_AW-1:0] imem_addr,
    input  logic [31:0]              imem_data,
    input  logic                     start,
    input  logic [6:0]               prog_len,
    output mips_pkg::instr_word_t    instr,
    output logic                     instr_valid,
    output logic                     busy
);

    logic [31:0]              imem [0:`MIPS_IMEM_DEPTH-1];
    logic [`MIPS_IMEM_AW-1:0] pc;
    logic [6:0]               remaining;

    // load port, contents kept across reset.
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_data;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // issue sequencer
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            pc        <= '0;
            remaining <= '0;
        end else if (busy) begin
            pc        <= pc + 1'b1;
            remaining <= remaining - 1'b1;
            // last word goes out this cycle.
            if (remaining == 7'd1) begin
                busy <= 1'b0;
            end
        end else if (start && prog_len != 7'd0) begin
            busy      <= 1'b1;
            pc        <= '0;
            remaining <= prog_len;
        end
    end

    // one word per cycle while busy.
    assign instr       = imem[pc];
    assign instr_valid = busy;

endmodule

`default_nettype wire

/* src/control.sv */
`timescale 1ns/1ps
`default_nettype none

module control (
    input  logic [5:0] opcode,
    input  logic [5:0] func,
    output logic       reg_dst,
    output logic [1:0] alu_src,
    output logic       mem_to_reg,
    output logic       reg_write,
    output logic       mem_read,
    output logic       mem_write,
    output logic       branch,
    output logic [2:0] alu_op,
    output logic       jump,
    output logic       do_extend
);

    import mips_pkg::*;

    // alu_src[0] picks shamt for a, alu_src[1] picks imm for b.
    always_comb begin
        reg_dst    = 1'b0;
        alu_src    = 2'b00;
        mem_to_reg = 1'b0;
        reg_write  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        branch     = 1'b0;
        alu_op     = ALU_RTYPE;
        do_extend  = 1'b1;
        jump       = 1'b0;

        case (opcode)
            OPC_RTYPE: begin
                reg_write = 1'b1;
                reg_dst   = 1'b1;
                case (func)
                    FN_SLL, FN_SRL, FN_SRA: begin
                        alu_src[0] = 1'b1;
                    end
                    default: begin
                        alu_src = 2'b00;
                    end
                endcase
            end
            OPC_ADDI: begin
                alu_src   = 2'b10;
                reg_write = 1'b1;
                alu_op    = ALU_ADDI;
            end
            OPC_ADDIU: begin
                alu_src   = 2'b10;
                reg_write = 1'b1;
                alu_op    = ALU_ADDIU;
            end
            // xori keeps the sign extension.
            OPC_XORI: begin
                alu_src   = 2'b10;
                reg_write = 1'b1;
                alu_op    = ALU_XORI;
            end
            OPC_LUI: begin
                alu_src   = 2'b10;
                reg_write = 1'b1;
                alu_op    = ALU_LUI;
            end
            OPC_ORI: begin
                alu_src   = 2'b10;
                reg_write = 1'b1;
                do_extend = 1'b0;
                alu_op    = ALU_ORI;
            end
            default: begin
                alu_src = 2'b00;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    // one instruction word, seen as r-type or i-type.
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
    } instr_word_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // alu_op encodings
    // ~~~~~~~~~~~~~~~~~~~~
    localparam logic [2:0] ALU_RTYPE = 3'b000;
    localparam logic [2:0] ALU_ADDI  = 3'b001;
    localparam logic [2:0] ALU_ADDIU = 3'b010;
    localparam logic [2:0] ALU_XORI  = 3'b100;
    localparam logic [2:0] ALU_ORI   = 3'b101;
    localparam logic [2:0] ALU_LUI   = 3'b111;

    // ~~~~~~~~~~~~~~~~~~~~
    // opcodes and functs
    // ~~~~~~~~~~~~~~~~~~~~
    localparam logic [5:0] OPC_RTYPE = 6'b000000;
    localparam logic [5:0] OPC_ADDI  = 6'b001000;
    localparam logic [5:0] OPC_ADDIU = 6'b001001;
    localparam logic [5:0] OPC_XORI  = 6'b001110;
    localparam logic [5:0] OPC_ORI   = 6'b001101;
    localparam logic [5:0] OPC_LUI   = 6'b001111;

    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_SLT  = 6'b101010;

endpackage

`default_nettype wire

/* include/mips_config.svh */
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~
// instruction memory
// ~~~~~~~~~~~~~~~~~~~~

// words held by the fetch stage.
`define MIPS_IMEM_DEPTH 64

// address bits for one word.
`define MIPS_IMEM_AW 6

// ~~~~~~~~~~~~~~~~~~~~
// register file
// ~~~~~~~~~~~~~~~~~~~~

`define MIPS_REG_COUNT 32

`endif
